// ==== sources.f ====
+incdir+bench
verilog/packetPkg.sv
verilog/nodePkg.sv
verilog/rewardTimer.sv
verilog/triggerDecode.sv
verilog/rewardController.sv
verilog/packetBuilder.sv
verilog/rewardTop.sv
bench/rewardTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the packing-stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module rewardTb \
    -Mdir obj_dir -f sources.f

./obj_dir/VrewardTb > sim.log 2>&1 || true
cat sim.log

# the log decides pass or fail
grep -q "SIMULATION PASSED" sim.log

// ==== bench/rewardCheck.svh ====
`ifndef REWARD_CHECK_SVH
`define REWARD_CHECK_SVH

// one value against its expectation
task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
        errors++;
        $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
endtask

// sink neighbors address the sink directly, others use their next hop
function automatic packetPkg::word_t routeTo(input nodePkg::nodeInfo_t n);
    if (n.hopsFromSink == 16'd1) begin
        return packetPkg::SINK_ID;
    end
    return n.chosenHop;
endfunction

// header that the packing rule asks for
function automatic packetPkg::packet_t expectHeader(
    input nodePkg::packKind_e kind,
    input nodePkg::nodeInfo_t n,
    input packetPkg::packet_t rx
);
    packetPkg::packet_t h;
    h = rx;
    case (kind)
        nodePkg::PACK_HB: begin
            h.sourceHops    = rx.sourceHops + 16'd1;
            h.destinationID = packetPkg::BROADCAST_ID;
        end
        nodePkg::PACK_INV: begin
            h.hopsFromCH    = rx.hopsFromCH + 16'd1;
            h.destinationID = packetPkg::BROADCAST_ID;
        end
        nodePkg::PACK_FWD: begin
            h.destinationID = routeTo(n);
        end
        nodePkg::PACK_MR, nodePkg::PACK_OWN: begin
            // built from own fields only
            h.pktType    = (kind == nodePkg::PACK_MR) ? packetPkg::PT_MR : packetPkg::PT_DATA;
            h.sourceID   = n.myNodeID;
            h.sourceHops = n.hopsFromSink;
            h.qValue     = n.myQValue;
            h.energyLeft = n.myEnergy;
            h.hopsFromCH = n.hopsFromCH;
            h.chosenCH   = n.chosenCH;
            h.destinationID = (kind == nodePkg::PACK_MR) ? n.chosenCH : routeTo(n);
        end
        default: begin
            h.pktType = packetPkg::PT_NONE;
        end
    endcase
    return h;
endfunction

// long range only for a request to a distant head
function automatic logic expectFar(input nodePkg::packKind_e kind, input nodePkg::nodeInfo_t n);
    return (kind == nodePkg::PACK_MR) && (n.hopsFromCH > 16'd1);
endfunction

// every header field plus the range bit
task automatic checkHeader(input packetPkg::packet_t exp, input logic expFar);
    checkValue("txPacket.pktType", 32'(txPacket.pktType), 32'(exp.pktType));
    checkValue("txPacket.sourceID", 32'(txPacket.sourceID), 32'(exp.sourceID));
    checkValue("txPacket.sourceHops", 32'(txPacket.sourceHops), 32'(exp.sourceHops));
    checkValue("txPacket.qValue", 32'(txPacket.qValue), 32'(exp.qValue));
    checkValue("txPacket.energyLeft", 32'(txPacket.energyLeft), 32'(exp.energyLeft));
    checkValue("txPacket.hopsFromCH", 32'(txPacket.hopsFromCH), 32'(exp.hopsFromCH));
    checkValue("txPacket.chosenCH", 32'(txPacket.chosenCH), 32'(exp.chosenCH));
    checkValue("txPacket.destinationID", 32'(txPacket.destinationID), 32'(exp.destinationID));
    checkValue("txFar", 32'(txFar), 32'(expFar));
endtask

`endif

// ==== bench/rewardTb.sv ====
`timescale 1ns/1ps

module rewardTb;

    localparam int TIMEOUT_RELOAD = 10;
    localparam int NUM_ROWS       = 13;
    // wait for packetValid
    localparam int PV_BOUND       = TIMEOUT_RELOAD + 8;
    // quiet check long enough to cover a join timeout
    localparam int QUIET_WINDOW   = TIMEOUT_RELOAD + 3;
    localparam int CYCLE_LIMIT    = NUM_ROWS * (TIMEOUT_RELOAD + 20);

    // one stimulus row with its expectation
    typedef struct packed {
        nodePkg::nodeInfo_t node;
        packetPkg::packet_t rx;
        logic               rxValid;
        logic               iAmDest;
        logic               iHaveData;
        logic [3:0]         grantDelay;
        logic               expectPack;
        nodePkg::packKind_e expKind;
    } row_t;

    logic               clk;
    logic               nrst;
    logic               rxValid;
    packetPkg::packet_t rxPacket;
    logic               iAmDestination;
    logic               iHaveData;
    nodePkg::nodeInfo_t node;
    logic               okToSend;
    packetPkg::packet_t txPacket;
    logic               packetValid;
    logic               txFar;
    logic               rewardDone;

    int   errors;
    int   checks;
    int   cycles = 0;
    int   idx;
    row_t rows [NUM_ROWS];

    `include "rewardCheck.svh"

    rewardTop DUT (
        .clk            (clk),
        .nrst           (nrst),
        .rxValid        (rxValid),
        .rxPacket       (rxPacket),
        .iAmDestination (iAmDestination),
        .iHaveData      (iHaveData),
        .node           (node),
        .okToSend       (okToSend),
        .txPacket       (txPacket),
        .packetValid    (packetValid),
        .txFar          (txFar),
        .rewardDone     (rewardDone)
    );

    always #20 clk = ~clk;

    // hang guard
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run hit the limit of %0d cycles, %0d errors so far", CYCLE_LIMIT, errors);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic nodePkg::nodeInfo_t makeNode(input nodePkg::role_e role,
        input packetPkg::word_t id, input packetPkg::word_t sinkHops,
        input packetPkg::word_t chHops, input packetPkg::word_t hop);
        nodePkg::nodeInfo_t n;
        n.myNodeID     = id;
        n.hopsFromSink = sinkHops;
        n.myQValue     = 16'h0300 + id;
        n.myEnergy     = 16'h7f00 - id;
        n.role         = role;
        n.chosenCH     = 16'h00c1;
        n.hopsFromCH   = chHops;
        n.chosenHop    = hop;
        return n;
    endfunction

    function automatic packetPkg::packet_t makeRx(input packetPkg::pktType_e t,
        input packetPkg::word_t src, input packetPkg::word_t srcHops,
        input packetPkg::word_t chHops);
        packetPkg::packet_t p;
        p.pktType       = t;
        p.sourceID      = src;
        p.sourceHops    = srcHops;
        p.qValue        = 16'h0a11;
        p.energyLeft    = 16'h6000;
        p.hopsFromCH    = chHops;
        p.chosenCH      = 16'h0022;
        p.destinationID = 16'h0042;
        return p;
    endfunction

    // grant delays are drawn here in row order
    function automatic row_t makeRow(input nodePkg::nodeInfo_t n, input packetPkg::packet_t rx,
        input logic v, input logic dest, input logic own, input logic packDue,
        input nodePkg::packKind_e kind);
        row_t r;
        r.node       = n;
        r.rx         = rx;
        r.rxValid    = v;
        r.iAmDest    = dest;
        r.iHaveData  = own;
        r.grantDelay = 4'($urandom_range(7, 0));
        r.expectPack = packDue;
        r.expKind    = kind;
        return r;
    endfunction

    task automatic buildTable();
        nodePkg::nodeInfo_t head3;
        nodePkg::nodeInfo_t head1;
        nodePkg::nodeInfo_t memNear;
        nodePkg::nodeInfo_t memFar;
        nodePkg::nodeInfo_t mem1;
        packetPkg::packet_t hb;
        packetPkg::packet_t inv2;
        packetPkg::packet_t inv4;
        packetPkg::packet_t data;
        head3   = makeNode(nodePkg::ROLE_HEAD, 16'h0011, 16'd3, 16'd1, 16'h0021);
        head1   = makeNode(nodePkg::ROLE_HEAD, 16'h0012, 16'd1, 16'd1, 16'h0022);
        memNear = makeNode(nodePkg::ROLE_MEMBER, 16'h0013, 16'd2, 16'd1, 16'h0023);
        memFar  = makeNode(nodePkg::ROLE_MEMBER, 16'h0014, 16'd4, 16'd3, 16'h0024);
        mem1    = makeNode(nodePkg::ROLE_MEMBER, 16'h0015, 16'd1, 16'd2, 16'h0025);
        hb      = makeRx(packetPkg::PT_HB, 16'h0031, 16'd2, 16'd0);
        inv2    = makeRx(packetPkg::PT_INV, 16'h0032, 16'd5, 16'd2);
        inv4    = makeRx(packetPkg::PT_INV, 16'h0033, 16'd5, 16'd4);
        data    = makeRx(packetPkg::PT_DATA, 16'h0034, 16'd6, 16'd2);
        // first heartbeat sets the lock and the second one is dropped
        rows[0]  = makeRow(head3, hb, 1'b1, 1'b0, 1'b0, 1'b1, nodePkg::PACK_HB);
        rows[1]  = makeRow(head3, hb, 1'b1, 1'b0, 1'b0, 1'b0, nodePkg::PACK_NONE);
        rows[2]  = makeRow(head3, inv2, 1'b1, 1'b0, 1'b0, 1'b1, nodePkg::PACK_INV);
        rows[3]  = makeRow(head3, inv4, 1'b1, 1'b0, 1'b0, 1'b0, nodePkg::PACK_NONE);
        // join timeout with a near and a far head, then a head that never asks
        rows[4]  = makeRow(memNear, hb, 1'b0, 1'b0, 1'b0, 1'b1, nodePkg::PACK_MR);
        rows[5]  = makeRow(memFar, hb, 1'b0, 1'b0, 1'b0, 1'b1, nodePkg::PACK_MR);
        rows[6]  = makeRow(head3, hb, 1'b0, 1'b0, 1'b0, 1'b0, nodePkg::PACK_NONE);
        rows[7]  = makeRow(head3, data, 1'b1, 1'b0, 1'b0, 1'b0, nodePkg::PACK_NONE);
        // forwarding clears the lock
        rows[8]  = makeRow(head3, data, 1'b1, 1'b1, 1'b0, 1'b1, nodePkg::PACK_FWD);
        rows[9]  = makeRow(head3, hb, 1'b1, 1'b0, 1'b0, 1'b1, nodePkg::PACK_HB);
        rows[10] = makeRow(head1, data, 1'b1, 1'b1, 1'b0, 1'b1, nodePkg::PACK_FWD);
        rows[11] = makeRow(memNear, hb, 1'b0, 1'b0, 1'b1, 1'b1, nodePkg::PACK_OWN);
        rows[12] = makeRow(mem1, hb, 1'b0, 1'b0, 1'b1, 1'b1, nodePkg::PACK_OWN);
    endtask

    task automatic runRow(input int i);
        row_t               r;
        packetPkg::packet_t exp;
        logic               expFar;
        int                 waited;
        logic               rose;
        r      = rows[i];
        exp    = expectHeader(r.expKind, r.node, r.rx);
        expFar = expectFar(r.expKind, r.node);
        rose   = 1'b0;
        @(negedge clk);
        node           = r.node;
        rxPacket       = r.rx;
        rxValid        = r.rxValid;
        iAmDestination = r.iAmDest;
        iHaveData      = r.iHaveData;
        // strobe lasts one cycle
        @(negedge clk);
        rxValid        = 1'b0;
        iAmDestination = 1'b0;
        waited         = 1;
        if (!r.expectPack) begin
            while (waited < QUIET_WINDOW) begin
                rose = rose | packetValid;
                @(negedge clk);
                waited++;
            end
            if (rose) begin
                $display("packetValid rose in row %0d although nothing was due", i);
                errors++;
            end
            return;
        end
        while (!packetValid && waited < PV_BOUND) begin
            @(negedge clk);
            waited++;
        end
        if (!packetValid) begin
            $display("packetValid never rose in row %0d", i);
            errors++;
            return;
        end
        if ((r.expKind == nodePkg::PACK_MR) && (waited > TIMEOUT_RELOAD + 3)) begin
            $display("membership request in row %0d came late, after %0d cycles", i, waited);
            errors++;
        end
        checkHeader(exp, expFar);
        // offer held while the channel is busy
        repeat (r.grantDelay) begin
            @(negedge clk);
            checkValue("packetValid", 32'(packetValid), 32'd1);
            checkHeader(exp, expFar);
        end
        okToSend = 1'b1;
        @(negedge clk);
        okToSend = 1'b0;
        checkValue("packetValid", 32'(packetValid), 32'd0);
        checkValue("rewardDone", 32'(rewardDone), 32'd1);
        // upstream drops its request on the done pulse
        iHaveData = 1'b0;
        @(negedge clk);
        checkValue("rewardDone", 32'(rewardDone), 32'd0);
    endtask

    initial begin
        clk            = 1'b0;
        nrst           = 1'b0;
        rxValid        = 1'b0;
        rxPacket       = '0;
        iAmDestination = 1'b0;
        iHaveData      = 1'b0;
        node           = '0;
        okToSend       = 1'b0;
        errors         = 0;
        checks         = 0;
        void'($urandom(32'h333a_b43c));
        buildTable();
        repeat (2) @(negedge clk);
        nrst = 1'b1;
        // reset values
        checkValue("packetValid", 32'(packetValid), 32'd0);
        checkValue("rewardDone", 32'(rewardDone), 32'd0);
        checkValue("txFar", 32'(txFar), 32'd0);
        checkValue("txPacket.pktType", 32'(txPacket.pktType), 32'(packetPkg::PT_NONE));
        for (idx = 0; idx < NUM_ROWS; idx++) begin
            runRow(idx);
        end
        $display("%0d rows, %0d checks, %0d errors", NUM_ROWS, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/rewardTop.sv ====
`timescale 1ns/1ps

// packet-packing stage of a clustered sensor node
module rewardTop #(
    parameter int TIMEOUT_RELOAD = 10,
    parameter int MAX_INV_HOPS   = 4
) (
    input  logic               clk,
    input  logic               nrst,
    input  logic               rxValid,
    input  packetPkg::packet_t rxPacket,
    input  logic               iAmDestination,
    input  logic               iHaveData,
    input  nodePkg::nodeInfo_t node,
    input  logic               okToSend,
    output packetPkg::packet_t txPacket,
    output logic               packetValid,
    output logic               txFar,
    output logic               rewardDone
);

    logic               expired;
    nodePkg::packKind_e kind;
    logic               idle;
    logic               latch;
    logic               hbLock;

    // join timeout for members
    rewardTimer #(
        .TIMEOUT_RELOAD (TIMEOUT_RELOAD)
    ) uTimer (
        .clk     (clk),
        .nrst    (nrst),
        .idle    (idle),
        .hbLock  (hbLock),
        .role    (node.role),
        .expired (expired)
    );

    // event priority
    triggerDecode #(
        .MAX_INV_HOPS (MAX_INV_HOPS)
    ) uDecode (
        .rxValid        (rxValid),
        .rxPacket       (rxPacket),
        .iAmDestination (iAmDestination),
        .iHaveData      (iHaveData),
        .role           (node.role),
        .expired        (expired),
        .hbLock         (hbLock),
        .idle           (idle),
        .kind           (kind)
    );

    rewardController uCtrl (
        .clk         (clk),
        .nrst        (nrst),
        .kind        (kind),
        .okToSend    (okToSend),
        .idle        (idle),
        .latch       (latch),
        .packetValid (packetValid),
        .rewardDone  (rewardDone),
        .hbLock      (hbLock)
    );

    // header registers
    packetBuilder uBuilder (
        .clk      (clk),
        .nrst     (nrst),
        .latch    (latch),
        .kind     (kind),
        .rxPacket (rxPacket),
        .node     (node),
        .txPacket (txPacket),
        .txFar    (txFar)
    );

endmodule

// ==== verilog/packetBuilder.sv ====
`timescale 1ns/1ps

// assembles the outgoing header for the chosen pack kind
module packetBuilder (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  latch,
    input  nodePkg::packKind_e    kind,
    input  packetPkg::packet_t    rxPacket,
    input  nodePkg::nodeInfo_t    node,
    output packetPkg::packet_t    txPacket,
    output logic                  txFar
);

    packetPkg::packet_t nextPacket;
    packetPkg::word_t   nextHop;
    logic               nextFar;

    // neighbors of the sink talk to it directly
    assign nextHop = (node.hopsFromSink == packetPkg::word_t'(1))
        ? packetPkg::SINK_ID : node.chosenHop;

    always_comb begin
        nextPacket = txPacket;
        nextFar    = txFar;
        case (kind)
            nodePkg::PACK_HB: begin
                // ripple with one more hop from the sink
                nextPacket               = rxPacket;
                nextPacket.pktType       = packetPkg::PT_HB;
                nextPacket.sourceHops    = rxPacket.sourceHops + 1'b1;
                nextPacket.destinationID = packetPkg::BROADCAST_ID;
                nextFar                  = 1'b0;
            end
            nodePkg::PACK_INV: begin
                // one more hop from the inviting head
                nextPacket               = rxPacket;
                nextPacket.pktType       = packetPkg::PT_INV;
                nextPacket.hopsFromCH    = rxPacket.hopsFromCH + 1'b1;
                nextPacket.destinationID = packetPkg::BROADCAST_ID;
                nextFar                  = 1'b0;
            end
            nodePkg::PACK_MR: begin
                nextPacket.pktType       = packetPkg::PT_MR;
                nextPacket.sourceID      = node.myNodeID;
                nextPacket.sourceHops    = node.hopsFromSink;
                nextPacket.qValue        = node.myQValue;
                nextPacket.energyLeft    = node.myEnergy;
                nextPacket.hopsFromCH    = node.hopsFromCH;
                nextPacket.chosenCH      = node.chosenCH;
                nextPacket.destinationID = node.chosenCH;
                // distant head needs the long range
                nextFar = (node.hopsFromCH > packetPkg::word_t'(1));
            end
            nodePkg::PACK_FWD: begin
                // payload untouched, only readdressed
                nextPacket               = rxPacket;
                nextPacket.destinationID = nextHop;
                nextFar                  = 1'b0;
            end
            nodePkg::PACK_OWN: begin
                nextPacket.pktType       = packetPkg::PT_DATA;
                nextPacket.sourceID      = node.myNodeID;
                nextPacket.sourceHops    = node.hopsFromSink;
                nextPacket.qValue        = node.myQValue;
                nextPacket.energyLeft    = node.myEnergy;
                nextPacket.hopsFromCH    = node.hopsFromCH;
                nextPacket.chosenCH      = node.chosenCH;
                nextPacket.destinationID = nextHop;
                nextFar                  = 1'b0;
            end
            default: begin
                // no job keeps the last header
                nextPacket = txPacket;
                nextFar    = txFar;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            // empty header until the first job
            txPacket         <= '0;
            txPacket.pktType <= packetPkg::PT_NONE;
            txFar            <= 1'b0;
        end else if (latch) begin
            txPacket <= nextPacket;
            txFar    <= nextFar;
        end
    end

    // header held steady through process and done
    assert property (@(posedge clk) disable iff (!nrst)
        !latch |=> $stable(txPacket) && $stable(txFar))
        else $error("txPacket changed without latch");

endmodule

// ==== verilog/rewardController.sv ====
`timescale 1ns/1ps

// idle/process/done sequencing of one packing job
module rewardController (
    input  logic               clk,
    input  logic               nrst,
    input  nodePkg::packKind_e kind,
    input  logic               okToSend,
    output logic               idle,
    output logic               latch,
    output logic               packetValid,
    output logic               rewardDone,
    output logic               hbLock
);

    typedef enum logic [1:0] {
        ST_IDLE    = 2'd0,
        ST_PROCESS = 2'd1,
        ST_DONE    = 2'd2
    } state_e;

    state_e             state;
    nodePkg::packKind_e kindReg;
    logic               grant;

    assign idle  = (state == ST_IDLE);
    // header load strobe
    assign latch = idle && (kind != nodePkg::PACK_NONE);
    // header is offered for the whole done state
    assign packetValid = (state == ST_DONE);
    assign grant       = packetValid && okToSend;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (latch) begin
                        state <= ST_PROCESS;
                    end
                end
                // one cycle for the header to settle
                ST_PROCESS: begin
                    state <= ST_DONE;
                end
                ST_DONE: begin
                    // wait for channel access
                    if (okToSend) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // remember the job so the lock can follow it at the grant
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            kindReg <= nodePkg::PACK_NONE;
        end else if (latch) begin
            kindReg <= kind;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            hbLock <= 1'b0;
        end else if (grant) begin
            // heartbeat sent once per round
            if (kindReg == nodePkg::PACK_HB) begin
                hbLock <= 1'b1;
            end else if ((kindReg == nodePkg::PACK_FWD) || (kindReg == nodePkg::PACK_OWN)) begin
                // data traffic means a new round may start
                hbLock <= 1'b0;
            end
        end
    end

    // single-cycle completion pulse after the grant
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rewardDone <= 1'b0;
        end else begin
            rewardDone <= grant;
        end
    end

    assert property (@(posedge clk) disable iff (!nrst)
        rewardDone |=> !rewardDone)
        else $error("rewardDone lasted two cycles");

    // offer must not be withdrawn before the grant
    assert property (@(posedge clk) disable iff (!nrst)
        packetValid && !okToSend |=> packetValid)
        else $error("packetValid dropped without okToSend");

endmodule

// ==== verilog/triggerDecode.sv ====
`timescale 1ns/1ps

// picks the single pack kind for this cycle
module triggerDecode #(
    parameter int MAX_INV_HOPS = 4
) (
    input  logic                  rxValid,
    input  packetPkg::packet_t    rxPacket,
    input  logic                  iAmDestination,
    input  logic                  iHaveData,
    input  nodePkg::role_e        role,
    input  logic                  expired,
    input  logic                  hbLock,
    input  logic                  idle,
    output nodePkg::packKind_e    kind
);

    logic mrDue;
    logic hbHit;
    logic invHit;
    logic fwdHit;

    // timeout only asks for a join on a member
    assign mrDue = expired && (role == nodePkg::ROLE_MEMBER);

    // first heartbeat only
    // later ones are dropped until the lock clears
    assign hbHit = rxValid
        && (rxPacket.pktType == packetPkg::PT_HB)
        && !hbLock;

    // invitations spread a limited number of hops from the head
    assign invHit = rxValid
        && (rxPacket.pktType == packetPkg::PT_INV)
        && (rxPacket.hopsFromCH < packetPkg::word_t'(MAX_INV_HOPS));

    // data addressed to us goes on toward the sink
    assign fwdHit = rxValid
        && (rxPacket.pktType == packetPkg::PT_DATA)
        && iAmDestination;

    always_comb begin
        kind = nodePkg::PACK_NONE;
        // busy stage takes nothing new
        if (idle) begin
            if (mrDue) begin
                kind = nodePkg::PACK_MR;
            end else if (hbHit) begin
                kind = nodePkg::PACK_HB;
            end else if (invHit) begin
                kind = nodePkg::PACK_INV;
            end else if (fwdHit) begin
                kind = nodePkg::PACK_FWD;
            end else if (iHaveData) begin
                // lowest priority, the request level waits for us
                kind = nodePkg::PACK_OWN;
            end
        end
    end

endmodule

// ==== verilog/rewardTimer.sv ====
`timescale 1ns/1ps

// member-side wait for invitations before asking to join a cluster
module rewardTimer #(
    parameter int TIMEOUT_RELOAD = 10
) (
    input  logic          clk,
    input  logic          nrst,
    input  logic          idle,
    input  logic          hbLock,
    input  nodePkg::role_e role,
    output logic          expired
);

    // just wide enough for the reload value
    localparam int CNT_W = $clog2(TIMEOUT_RELOAD + 1);

    logic [CNT_W-1:0] count;
    logic             reload;

    // counting only makes sense for an idle member that has seen a heartbeat
    // an expired count restarts so the request repeats later
    assign reload = !idle || !hbLock || (role != nodePkg::ROLE_MEMBER) || expired;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            count <= CNT_W'(TIMEOUT_RELOAD);
        end else if (reload) begin
            count <= CNT_W'(TIMEOUT_RELOAD);
        end else begin
            // one step per idle cycle
            count <= count - 1'b1;
        end
    end

    // stays high for the whole zero cycle
    assign expired = (count == '0);

    // down-counter must never wrap above its reload
    assert property (@(posedge clk) disable iff (!nrst)
        count <= CNT_W'(TIMEOUT_RELOAD))
        else $error("rewardTimer count above reload value");

endmodule

// ==== verilog/nodePkg.sv ====
// local node state as seen by the packing stage
package nodePkg;

    // cluster role of this node
    typedef enum logic {
        ROLE_MEMBER = 1'b0,
        ROLE_HEAD   = 1'b1
    } role_e;

    // what the packing stage has been asked to build
    typedef enum logic [2:0] {
        // nothing to send
        PACK_NONE = 3'd0,
        // ripple first heartbeat
        PACK_HB   = 3'd1,
        // ripple invitation one hop further
        PACK_INV  = 3'd2,
        // membership request to the chosen head
        PACK_MR   = 3'd3,
        // pass received data toward the sink
        PACK_FWD  = 3'd4,
        // own sensor data
        PACK_OWN  = 3'd5
    } packKind_e;

    // node information block
    typedef struct packed {
        packetPkg::word_t myNodeID;
        packetPkg::word_t hopsFromSink;
        packetPkg::word_t myQValue;
        packetPkg::word_t myEnergy;
        role_e            role;
        // head picked during cluster formation
        packetPkg::word_t chosenCH;
        packetPkg::word_t hopsFromCH;
        // next hop toward the sink
        packetPkg::word_t chosenHop;
    } nodeInfo_t;

endpackage

// ==== verilog/packetPkg.sv ====
// over-the-air packet format shared by the received and the sent side
package packetPkg;

    // every header field is one word wide
    localparam int WORD_W = 16;

    typedef logic [WORD_W-1:0] word_t;

    // packet type codes as carried in the 3-bit type field
    typedef enum logic [2:0] {
        PT_HB   = 3'd0,
        PT_CHE  = 3'd1,
        PT_INV  = 3'd2,
        PT_MR   = 3'd3,
        PT_CHT  = 3'd4,
        PT_DATA = 3'd5,
        PT_SOS  = 3'd6,
        PT_NONE = 3'd7
    } pktType_e;

    // header layout, type first and destination last
    typedef struct packed {
        pktType_e pktType;
        word_t    sourceID;
        // hops between the source and the sink
        word_t    sourceHops;
        word_t    qValue;
        word_t    energyLeft;
        // hops between the source and its cluster head
        word_t    hopsFromCH;
        word_t    chosenCH;
        word_t    destinationID;
    } packet_t;

    // all neighbors within range
    localparam word_t BROADCAST_ID = '1;

    // the sink always sits at address zero
    localparam word_t SINK_ID = '0;

endpackage
